/* l2_cache.f */
+incdir+verilog
verilog/l2_cache_pkg.sv
verilog/cache_ctrl_if.sv
verilog/cache_array.sv
verilog/cache_datapath.sv
verilog/cache_controller.sv
verilog/l2_cache.sv
verif/pmem_model.sv
verif/l2_cache_assert.sv
verif/l2_cache_tb.sv

/* verif/l2_cache_assert.sv */
`timescale 1ns/100ps
`default_nettype none

`include "l2_cache_params.svh"

module l2_cache_assert import l2_cache_pkg::*;
(
	input logic clk,
	input logic rst_n,
	input logic mem_read,
	input logic mem_write,
	input logic mem_resp,
	input logic [`L2_ADDR_W-1:0] pmem_addr,
	input logic pmem_read,
	input logic pmem_write,
	input line_t pmem_wdata,
	input logic pmem_resp,
	input logic hit,
	input ctrl_state_t state
);

	int error_count = 0;

	task automatic log_violation(input string what);
		$error("%s", what);
		error_count++;
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	reset_quiet: assert property (@(posedge clk) !rst_n |-> !pmem_read && !pmem_write && !mem_resp)
		else log_violation("memory request or mem_resp active during reset");
	resp_needs_request: assert property (@(posedge clk) disable iff (!rst_n)
		mem_resp |-> mem_read || mem_write) else log_violation("mem_resp without a request");
	hit_no_memory: assert property (@(posedge clk) disable iff (!rst_n)
		(state == check_tag) && hit && (mem_read || mem_write) |=> !pmem_read && !pmem_write)
		else log_violation("memory access started by a request that hits");
	pmem_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
		!(pmem_read && pmem_write)) else log_violation("pmem_read and pmem_write high together");
	read_held: assert property (@(posedge clk) disable iff (!rst_n)
		pmem_read && !pmem_resp |=> pmem_read && $stable(pmem_addr))
		else log_violation("memory read dropped or changed before pmem_resp");
	write_held: assert property (@(posedge clk) disable iff (!rst_n)
		pmem_write && !pmem_resp |=> pmem_write && $stable(pmem_addr) && $stable(pmem_wdata))
		else log_violation("memory write dropped or changed before pmem_resp");
	addr_aligned: assert property (@(posedge clk) disable iff (!rst_n)
		(pmem_read || pmem_write) |-> pmem_addr[`L2_OFFSET_W-1:0] == '0)
		else log_violation("pmem_addr is not line aligned");

endmodule : l2_cache_assert

bind l2_cache l2_cache_assert i_l2_cache_assert (.*, .hit(ctrl_bus.hit),
	.state(i_controller.state));

`default_nettype wire

/* verif/l2_cache_tb.sv */
`timescale 1ns/100ps
`default_nettype none

`include "l2_cache_params.svh"

module l2_cache_tb import l2_cache_pkg::*;
();

	localparam int seed_init = 28996;
	localparam int min_latency = 1;
	localparam int max_latency = 4;
	localparam int clk_period = 8;
	localparam int reset_cycles = 16;
	localparam int resp_timeout = 100; // cycles, enough for a dirty miss.

	logic clk;
	logic rst_n;
	logic [`L2_ADDR_W-1:0] mem_addr;
	logic mem_read;
	logic mem_write;
	line_t mem_wdata;
	line_t mem_rdata;
	logic mem_resp;
	logic [`L2_ADDR_W-1:0] pmem_addr;
	logic pmem_read;
	logic pmem_write;
	line_t pmem_wdata;
	line_t pmem_rdata;
	logic pmem_resp;
	integer seed;

	l2_cache i_l2_cache (.*);

	pmem_model #(.seed_init(seed_init), .min_latency(min_latency), .max_latency(max_latency))
		i_pmem (.*);

	initial
	begin
		clk = 1'b0;
		forever #(clk_period / 2) clk = ~clk;
	end

	task automatic report_failure();
		$display("TESTBENCH FAILED");
		$fatal(1, "stopping at the first failure");
	endtask

	function automatic logic [`L2_ADDR_W-1:0] line_base(input logic [`L2_ADDR_W-1:0] addr);
		return {addr[`L2_ADDR_W-1:`L2_OFFSET_W], {`L2_OFFSET_W{1'b0}}};
	endfunction

	function automatic line_t random_line();
		line_t line;
		for (int w = 0; w < `L2_LINE_W / 32; w++)
			line[32*w +: 32] = $random(seed);
		return line;
	endfunction

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// the request is held until mem_resp is seen ahead of a rising edge.
	task automatic access(input logic is_write, input logic [`L2_ADDR_W-1:0] addr,
		input line_t wdata, output line_t rdata);
		int cycles;
		cycles = 0;
		mem_addr = addr;
		mem_read = !is_write;
		mem_write = is_write;
		mem_wdata = wdata;
		#(clk_period / 4);
		while (!mem_resp)
		begin
			cycles++;
			if (cycles > resp_timeout)
			begin
				$display("no mem_resp for address %h within %0d cycles", addr, resp_timeout);
				report_failure();
			end
			@(negedge clk);
			#(clk_period / 4);
		end
		rdata = mem_rdata;
		@(negedge clk);
		mem_read = 1'b0;
		mem_write = 1'b0;
	endtask

	task automatic expect_line(input string name, input line_t got, input line_t expected);
		assert (got === expected)
		else
		begin
			$display("[ERROR] %s = %h, expected %h", name, got, expected);
			report_failure();
		end
	endtask

	task automatic expect_count(input string name, input int got, input int expected);
		assert (got == expected)
		else
		begin
			$display("[ERROR] %s = %h, expected %h", name, got, expected);
			report_failure();
		end
	endtask

	always @(negedge clk)
	begin
		if (i_l2_cache.i_l2_cache_assert.error_count != 0)
		begin
			$display("a protocol assertion bound into l2_cache failed");
			report_failure();
		end
	end

	initial
	begin
		logic [`L2_ADDR_W-1:0] addr_a;
		logic [`L2_ADDR_W-1:0] addr_b;
		logic [`L2_ADDR_W-1:0] addr_c;
		logic [`L2_ADDR_W-1:0] addr_d;
		line_t data;
		line_t wdata_a;
		line_t wdata_d;
		int reads;
		int writes;

		seed = seed_init;
		addr_a = 32'h0001_2354; // a, b and c all map to set 2.
		addr_b = 32'h00ab_cd40;
		addr_c = 32'h0f0f_0f48;
		addr_d = 32'h0000_1088; // set 4.
		rst_n = 1'b0;
		mem_addr = '0;
		mem_read = 1'b0;
		mem_write = 1'b0;
		mem_wdata = '0;
		repeat (reset_cycles) @(negedge clk);
		rst_n = 1'b1;
		@(negedge clk);
		reads = i_pmem.reads_done;
		writes = i_pmem.writes_done;

		access(1'b0, addr_a, '0, data); // miss, then the same line hits.
		expect_line("mem_rdata", data, i_pmem.line_at(line_base(addr_a)));
		access(1'b0, addr_a, '0, data);
		expect_line("mem_rdata", data, i_pmem.line_at(line_base(addr_a)));
		expect_count("pmem reads", i_pmem.reads_done, reads + 1);

		wdata_a = random_line();
		access(1'b1, line_base(addr_a) + 32'h8, wdata_a, data);
		access(1'b0, addr_a, '0, data);
		expect_line("mem_rdata", data, wdata_a);
		expect_count("pmem reads", i_pmem.reads_done, reads + 1);
		expect_count("pmem writes", i_pmem.writes_done, writes);

		access(1'b0, addr_b, '0, data); // b takes the other way of set 2.
		expect_line("mem_rdata", data, i_pmem.line_at(line_base(addr_b)));
		access(1'b0, addr_c, '0, data); // a is least recent and dirty.
		expect_line("mem_rdata", data, i_pmem.line_at(line_base(addr_c)));
		expect_count("pmem writes", i_pmem.writes_done, writes + 1);
		expect_line("shadow line", i_pmem.line_at(line_base(addr_a)), wdata_a);
		access(1'b0, addr_b, '0, data);
		expect_line("mem_rdata", data, i_pmem.line_at(line_base(addr_b)));
		expect_count("pmem reads", i_pmem.reads_done, reads + 3);
		access(1'b0, addr_a, '0, data); // c leaves clean, a returns from memory.
		expect_line("mem_rdata", data, wdata_a);
		expect_count("pmem reads", i_pmem.reads_done, reads + 4);
		expect_count("pmem writes", i_pmem.writes_done, writes + 1);

		wdata_d = random_line();
		access(1'b1, addr_d, wdata_d, data); // write miss allocates first.
		access(1'b0, addr_d, '0, data);
		expect_line("mem_rdata", data, wdata_d);
		expect_count("pmem reads", i_pmem.reads_done, reads + 5);

		@(negedge clk);
		if (i_l2_cache.i_l2_cache_assert.error_count != 0)
		begin
			$display("a protocol assertion bound into l2_cache failed");
			report_failure();
		end
		else
		begin
			$display("TESTBENCH PASSED");
			$finish;
		end
	end

endmodule : l2_cache_tb

`default_nettype wire

/* verif/pmem_model.sv */
`timescale 1ns/100ps
`default_nettype none

`include "l2_cache_params.svh"

module pmem_model import l2_cache_pkg::*;
#(
	parameter int seed_init = 1,
	parameter int min_latency = 1,
	parameter int max_latency = 4
)
(
	input logic clk,
	input logic rst_n,
	input logic [`L2_ADDR_W-1:0] pmem_addr,
	input logic pmem_read,
	input logic pmem_write,
	input line_t pmem_wdata,
	output line_t pmem_rdata,
	output logic pmem_resp
);

	line_t shadow [logic [`L2_ADDR_W-1:0]]; // lines written back so far.
	integer seed;
	int wait_left; // cycles until the open request is answered.
	int reads_done;
	int writes_done;

	initial
	begin
		seed = seed_init;
		pmem_resp = 1'b0;
		pmem_rdata = '0;
		wait_left = 0;
	end

	// a line that was never written holds a pattern built from its address.
	function automatic line_t line_at(input logic [`L2_ADDR_W-1:0] addr);
		line_t line;
		if (shadow.exists(addr))
			return shadow[addr];
		for (int w = 0; w < `L2_LINE_W / 32; w++)
			line[32*w +: 32] = (addr + 4 * w) ^ 32'h6b2f_91d0;
		return line;
	endfunction

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always @(negedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			pmem_resp <= 1'b0;
			wait_left = 0;
		end
		else
		begin
			pmem_resp <= 1'b0; // the response lasts a single cycle.
			if (wait_left > 0)
			begin
				wait_left--;
				if (wait_left == 0)
				begin
					pmem_resp <= 1'b1;
					if (pmem_write)
					begin
						shadow[pmem_addr] = pmem_wdata;
						writes_done++;
					end
					else
					begin
						pmem_rdata <= line_at(pmem_addr);
						reads_done++;
					end
				end
			end
			else if (pmem_read || pmem_write)
				wait_left = min_latency + ({$random(seed)} % (max_latency - min_latency + 1));
		end
	end

endmodule : pmem_model

`default_nettype wire

/* verilog/cache_array.sv */
`timescale 1ns/100ps
`default_nettype none

`include "l2_cache_params.svh"

module cache_array import l2_cache_pkg::*;
#(
	parameter type payload_t = line_t
)
(
	input logic clk,
	input logic rst_n,
	input logic load,
	input index_t index,
	input payload_t datain,
	output payload_t dataout
);

	payload_t entries [`L2_SETS];

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			for (int i = 0; i < `L2_SETS; i++)
				entries[i] <= '0; // zero clears valid and dirty in metadata.
		end
		else if (load)
		begin
			entries[index] <= datain;
		end
	end

	// read is combinational so a hit answers in the request cycle.
	assign dataout = entries[index];

endmodule : cache_array

`default_nettype wire

/* verilog/cache_controller.sv */
`timescale 1ns/100ps
`default_nettype none

module cache_controller import l2_cache_pkg::*;
(
	input logic clk,
	input logic rst_n,
	input logic mem_read,
	input logic mem_write,
	output logic mem_resp,
	input logic pmem_resp,
	cache_ctrl_if.ctrl bus
);

	ctrl_state_t state;
	ctrl_state_t next_state;
	logic request;

	assign request = mem_read || mem_write;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Next state and command decode.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_comb
	begin
		next_state = state;
		mem_resp = 1'b0;
		bus.write_hit = 1'b0;
		bus.fill = 1'b0;
		bus.mem_start_read = 1'b0;
		bus.mem_start_write = 1'b0;
		bus.mem_done = 1'b0;
		bus.out_sel_victim = 1'b0;

		case (state)
			check_tag:
			begin
				if (request)
				begin
					if (bus.hit)
					begin
						mem_resp = 1'b1; // answered in the request cycle.
						bus.write_hit = mem_write;
					end
					else if (bus.victim_dirty)
					begin
						bus.out_sel_victim = 1'b1; // victim line goes to the write-back register.
						bus.mem_start_write = 1'b1;
						next_state = write_back;
					end
					else
					begin
						bus.mem_start_read = 1'b1;
						next_state = allocate;
					end
				end
			end

			write_back:
			begin
				if (pmem_resp)
				begin
					bus.mem_done = 1'b1;
					bus.mem_start_read = 1'b1; // the fetch follows at once.
					next_state = allocate;
				end
			end

			allocate:
			begin
				if (pmem_resp)
				begin
					bus.mem_done = 1'b1;
					bus.fill = 1'b1;
					next_state = check_tag; // the retry then hits.
				end
			end

			default:
			begin
				next_state = check_tag;
			end
		endcase
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			state <= check_tag;
		else
			state <= next_state;
	end

endmodule : cache_controller

`default_nettype wire

/* verilog/cache_ctrl_if.sv */
`timescale 1ns/100ps
`default_nettype none

interface cache_ctrl_if;

	// status from the datapath.
	logic hit;
	logic hit_way; // way 1 matched when high.
	logic victim_way;
	logic victim_dirty;

	// commands from the controller.
	logic write_hit;
	logic fill;
	logic mem_start_read;
	logic mem_start_write;
	logic mem_done;
	logic out_sel_victim;

	modport ctrl (
		input hit, hit_way, victim_way, victim_dirty,
		output write_hit, fill, mem_start_read, mem_start_write, mem_done, out_sel_victim
	);

	modport dp (
		output hit, hit_way, victim_way, victim_dirty,
		input write_hit, fill, mem_start_read, mem_start_write, mem_done, out_sel_victim
	);

endinterface : cache_ctrl_if

`default_nettype wire

/* verilog/cache_datapath.sv */
`timescale 1ns/100ps
`default_nettype none

`include "l2_cache_params.svh"

module cache_datapath import l2_cache_pkg::*;
(
	input logic clk,
	input logic rst_n,
	input logic [`L2_ADDR_W-1:0] mem_addr,
	input line_t mem_wdata,
	output line_t mem_rdata,
	input line_t pmem_rdata,
	output logic [`L2_ADDR_W-1:0] pmem_addr,
	output line_t pmem_wdata,
	output logic pmem_read,
	output logic pmem_write,
	cache_ctrl_if.dp bus
);

	tag_t tag;
	index_t index;
	meta_t meta_in;
	meta_t meta_out [2];
	line_t data_in;
	line_t data_out [2];
	logic meta_load [2];
	logic data_load [2];
	logic way_hit [2];
	logic [`L2_SETS-1:0] lru; // one bit per set, names the way to evict.
	line_t line_out;
	logic [`L2_ADDR_W-1:0] line_addr;
	logic [`L2_ADDR_W-1:0] wb_addr;

	assign tag = mem_addr[`L2_ADDR_W-1 -: `L2_TAG_W];
	assign index = mem_addr[`L2_OFFSET_W +: `L2_INDEX_W];

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Tag and data storage, one pair of arrays per way.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// a write hit marks the line dirty, a fill brings it in clean.
	assign meta_in = '{valid: 1'b1, dirty: bus.write_hit, tag: tag};
	assign data_in = bus.fill ? pmem_rdata : mem_wdata;

	for (genvar w = 0; w < 2; w++)
	begin : g_way
		assign way_hit[w] = meta_out[w].valid && (meta_out[w].tag == tag);
		assign meta_load[w] = (bus.write_hit && (bus.hit_way == w))
			|| (bus.fill && (bus.victim_way == w));
		assign data_load[w] = meta_load[w];

		cache_array #(.payload_t(meta_t)) i_meta (
			.clk,
			.rst_n,
			.load(meta_load[w]),
			.index,
			.datain(meta_in),
			.dataout(meta_out[w])
		);

		cache_array #(.payload_t(line_t)) i_data (
			.clk,
			.rst_n,
			.load(data_load[w]),
			.index,
			.datain(data_in),
			.dataout(data_out[w])
		);
	end

	assign bus.hit = way_hit[0] || way_hit[1];
	assign bus.hit_way = way_hit[1];
	assign bus.victim_way = lru[index];
	assign bus.victim_dirty = meta_out[bus.victim_way].valid && meta_out[bus.victim_way].dirty;

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			lru <= '0;
		else if (bus.hit)
			lru[index] <= ~bus.hit_way; // the other way is now least recent.
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Line output and memory port.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	assign line_out = bus.out_sel_victim ? data_out[bus.victim_way] : data_out[bus.hit_way];
	assign mem_rdata = line_out;

	assign line_addr = {tag, index, {`L2_OFFSET_W{1'b0}}};
	// victim address is rebuilt from its stored tag and the shared index.
	assign wb_addr = {meta_out[bus.victim_way].tag, index, {`L2_OFFSET_W{1'b0}}};

	// a start wins over mem_done so write-back can chain straight into allocate.
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			pmem_read <= 1'b0;
			pmem_write <= 1'b0;
			pmem_addr <= '0;
			pmem_wdata <= '0;
		end
		else if (bus.mem_start_read)
		begin
			pmem_read <= 1'b1;
			pmem_write <= 1'b0;
			pmem_addr <= line_addr;
		end
		else if (bus.mem_start_write)
		begin
			pmem_read <= 1'b0;
			pmem_write <= 1'b1;
			pmem_addr <= wb_addr;
			pmem_wdata <= line_out;
		end
		else if (bus.mem_done)
		begin
			pmem_read <= 1'b0;
			pmem_write <= 1'b0;
			pmem_addr <= '0;
			pmem_wdata <= '0;
		end
	end

endmodule : cache_datapath

`default_nettype wire

/* verilog/l2_cache.sv */
`timescale 1ns/100ps
`default_nettype none

`include "l2_cache_params.svh"

module l2_cache import l2_cache_pkg::*;
(
	input logic clk,
	input logic rst_n,

	// requester side.
	input logic [`L2_ADDR_W-1:0] mem_addr,
	input logic mem_read,
	input logic mem_write,
	input line_t mem_wdata,
	output line_t mem_rdata,
	output logic mem_resp,

	// memory side.
	output logic [`L2_ADDR_W-1:0] pmem_addr,
	output logic pmem_read,
	output logic pmem_write,
	output line_t pmem_wdata,
	input line_t pmem_rdata,
	input logic pmem_resp
);

	cache_ctrl_if ctrl_bus ();

	cache_controller i_controller (
		.clk,
		.rst_n,
		.mem_read,
		.mem_write,
		.mem_resp,
		.pmem_resp,
		.bus(ctrl_bus.ctrl)
	);

	cache_datapath i_datapath (
		.clk,
		.rst_n,
		.mem_addr,
		.mem_wdata,
		.mem_rdata,
		.pmem_rdata,
		.pmem_addr,
		.pmem_wdata,
		.pmem_read,
		.pmem_write,
		.bus(ctrl_bus.dp)
	);

endmodule : l2_cache

`default_nettype wire

/* verilog/l2_cache_params.svh */
`ifndef L2_CACHE_PARAMS_SVH
`define L2_CACHE_PARAMS_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Address split and line geometry of the cache.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`define L2_ADDR_W 32 // byte address width on both sides.
`define L2_OFFSET_W 5 // 32 bytes per line.
`define L2_INDEX_W 3
`define L2_TAG_W 24 // what is left of the address above index and offset.
`define L2_LINE_W 256
`define L2_SETS 8 // must equal 2**L2_INDEX_W.

`endif

/* verilog/l2_cache_pkg.sv */
`default_nettype none

`include "l2_cache_params.svh"

package l2_cache_pkg;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Payload and index types.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	typedef logic [`L2_LINE_W-1:0] line_t;
	typedef logic [`L2_TAG_W-1:0] tag_t;
	typedef logic [`L2_INDEX_W-1:0] index_t;

	// one way of one set, 26 bits wide.
	typedef struct packed {
		logic valid;
		logic dirty; // line differs from memory.
		tag_t tag;
	} meta_t;

	typedef enum logic [1:0] {
		check_tag,
		write_back,
		allocate
	} ctrl_state_t;

endpackage : l2_cache_pkg

`default_nettype wire
